/* pool_pkg.sv */
// ================================================
// Shared widths, types and the job configuration
// for the max-pooling core. Imported by every block
// ================================================
`default_nettype none

package pool_pkg;

    // ================================================
    // Widths
    // ================================================
    localparam int IDX_WIDTH    = 16;
    localparam int ACT_WIDTH    = 8;
    localparam int LANES        = 4;
    localparam int SRAM_WIDTH   = 64;
    localparam int MAP_POINTS   = 8;
    localparam int MAP_WORDS    = 2;
    // Map indices carried by one SRAM word
    localparam int IDX_PER_WORD = SRAM_WIDTH / IDX_WIDTH;

    // ================================================
    // Types
    // ================================================
    typedef logic [IDX_WIDTH-1:0]  idx_t;
    typedef logic [ACT_WIDTH-1:0]  act_t;
    typedef act_t [LANES-1:0]      lane_vec_t;
    typedef logic [SRAM_WIDTH-1:0] sram_word_t;
    // Entry 0 sits in the low bits of map word 0
    typedef idx_t [MAP_POINTS-1:0] map_arr_t;
    typedef logic [3:0]            kpt_t;
    typedef logic [7:0]            grp_t;

    typedef struct packed {
        kpt_t k;            // neighbors pooled, 1 to MAP_POINTS
        grp_t chn_grp;      // lane groups per point
        idx_t nip;          // output points
        idx_t map_rd_base;
        idx_t ofm_rd_base;
        idx_t ofm_wr_base;
    } pool_cfg_t;

    typedef enum logic [1:0] {
        IDLE,
        MAP_IN,
        DRAIN
    } pool_state_e;

endpackage

`default_nettype wire

/* pool_loop_counter.sv */
// ================================================
// Wrapping loop counter with a runtime maximum.
// Chain instances through wrap for nested loops
// ================================================
`timescale 1ns/1ns
`default_nettype none

module pool_loop_counter #(
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             clear,
    input  logic             inc,
    input  logic [WIDTH-1:0] max,
    output logic [WIDTH-1:0] count,
    output logic             wrap
);

    // Last iteration of this loop level
    assign wrap = (count == max);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (inc) begin
            count <= wrap ? '0 : count + 1'b1;
        end
    end

    // Max is held for a whole job, so the count must stay in range
    a_count_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        !clear |-> (count <= max)
    );

endmodule

`default_nettype wire

/* pool_ctrl_fsm.sv */
// ================================================
// Job FSM. Takes one configuration, holds it for
// the job and waits for fetch and write-back to end
// ================================================
`timescale 1ns/1ns
`default_nettype none

module pool_ctrl_fsm import pool_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  pool_cfg_t cfg,
    input  logic      cfg_valid,
    output logic      cfg_ready,
    input  logic      fetch_done,
    input  logic      job_done,
    output pool_cfg_t job_cfg,
    output logic      busy
);

    pool_state_e state_q;

    assign cfg_ready = (state_q == IDLE);
    assign busy      = (state_q != IDLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE:    if (cfg_valid) state_q <= MAP_IN;
                // All map addresses sent, only feature traffic left
                MAP_IN:  if (fetch_done) state_q <= DRAIN;
                DRAIN:   if (job_done) state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    // New configurations are only taken in IDLE
    always_ff @(posedge clk) begin
        if (cfg_valid && cfg_ready) begin
            job_cfg <= cfg;
        end
    end

    // The last write can only follow a started job
    a_no_done_in_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        job_done |-> (state_q != IDLE)
    );

endmodule

`default_nettype wire

/* map_fetch.sv */
// ================================================
// Map fetch. Reads MAP_WORDS words per point and
// packs them into one map, single buffered
// ================================================
`timescale 1ns/1ns
`default_nettype none

module map_fetch import pool_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  pool_cfg_t  job_cfg,
    input  logic       busy,
    output idx_t       map_rd_addr,
    output logic       map_rd_addr_valid,
    input  logic       map_rd_addr_ready,
    input  sram_word_t map_rd_dat,
    input  logic       map_rd_dat_valid,
    output logic       map_rd_dat_ready,
    output map_arr_t   map_arr,
    output logic       map_valid,
    input  logic       map_ready,
    output logic       fetch_done
);

    localparam int WORD_W = $clog2(MAP_WORDS);

    idx_t              pt_cnt;
    logic              pt_wrap;
    logic [WORD_W-1:0] wd_cnt;
    logic              wd_wrap;
    logic [WORD_W-1:0] fill_cnt;
    logic              map_full;
    logic              addr_hold;
    logic              addr_done;
    logic              addr_hs;
    logic              dat_hs;
    logic              map_hs;

    // ================================================
    // Address side
    // ================================================
    assign addr_hs    = map_rd_addr_valid && map_rd_addr_ready;
    assign fetch_done = addr_hs && pt_wrap && wd_wrap;

    assign map_rd_addr_valid = busy && !addr_hold && !addr_done;
    assign map_rd_addr = job_cfg.map_rd_base + idx_t'(pt_cnt * MAP_WORDS) + idx_t'(wd_cnt);

    pool_loop_counter #(.WIDTH(WORD_W)) word_cnt_i (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (!busy),
        .inc   (addr_hs),
        .max   (WORD_W'(MAP_WORDS - 1)),
        .count (wd_cnt),
        .wrap  (wd_wrap)
    );

    pool_loop_counter #(.WIDTH(IDX_WIDTH)) point_cnt_i (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (!busy),
        .inc   (addr_hs && wd_wrap),
        .max   (job_cfg.nip - 1'b1),
        .count (pt_cnt),
        .wrap  (pt_wrap)
    );

    // Stop after a whole point until the map is taken
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_hold <= 1'b0;
            addr_done <= 1'b0;
        end else if (!busy) begin
            addr_hold <= 1'b0;
            addr_done <= 1'b0;
        end else begin
            if (addr_hs && wd_wrap) begin
                addr_hold <= 1'b1;
            end else if (map_hs) begin
                addr_hold <= 1'b0;
            end
            if (fetch_done) begin
                addr_done <= 1'b1;
            end
        end
    end

    // ================================================
    // Data side
    // ================================================
    assign dat_hs           = map_rd_dat_valid && map_rd_dat_ready;
    assign map_hs           = map_valid && map_ready;
    assign map_rd_dat_ready = busy && !map_full;
    assign map_valid        = map_full;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_cnt <= '0;
            map_full <= 1'b0;
        end else if (!busy) begin
            fill_cnt <= '0;
            map_full <= 1'b0;
        end else if (dat_hs) begin
            if (fill_cnt == WORD_W'(MAP_WORDS - 1)) begin
                fill_cnt <= '0;
                map_full <= 1'b1;
            end else begin
                fill_cnt <= fill_cnt + 1'b1;
            end
        end else if (map_hs) begin
            map_full <= 1'b0;
        end
    end

    // Words fill the map in arrival order
    always_ff @(posedge clk) begin
        if (dat_hs) begin
            map_arr[fill_cnt * IDX_PER_WORD +: IDX_PER_WORD] <= map_rd_dat;
        end
    end

    // Next point is only requested once the map is free
    a_no_word_while_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        map_rd_dat_valid |-> !map_full
    );

endmodule

`default_nettype wire

/* ofm_gather.sv */
// ================================================
// Feature gather. Walks groups (outer) and the
// first k neighbors (inner) of the current map
// ================================================
`timescale 1ns/1ns
`default_nettype none

module ofm_gather import pool_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  pool_cfg_t job_cfg,
    input  logic      busy,
    input  map_arr_t  map_arr,
    input  logic      map_valid,
    output logic      map_ready,
    output idx_t      ofm_rd_addr,
    output logic      ofm_rd_addr_valid,
    input  logic      ofm_rd_addr_ready
);

    localparam int SLOT_W = $clog2(MAP_POINTS);

    kpt_t nb_cnt;
    logic nb_wrap;
    grp_t grp_cnt;
    logic grp_wrap;
    idx_t nb_idx;
    logic addr_hs;

    assign ofm_rd_addr_valid = busy && map_valid;
    assign addr_hs           = ofm_rd_addr_valid && ofm_rd_addr_ready;

    // Last address of the point releases the map
    assign map_ready = addr_hs && nb_wrap && grp_wrap;

    // ================================================
    // Loop counters
    // ================================================
    pool_loop_counter #(.WIDTH($bits(kpt_t))) nb_cnt_i (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (!busy),
        .inc   (addr_hs),
        .max   (job_cfg.k - 1'b1),
        .count (nb_cnt),
        .wrap  (nb_wrap)
    );

    pool_loop_counter #(.WIDTH($bits(grp_t))) grp_cnt_i (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (!busy),
        .inc   (addr_hs && nb_wrap),
        .max   (job_cfg.chn_grp - 1'b1),
        .count (grp_cnt),
        .wrap  (grp_wrap)
    );

    // ================================================
    // Address
    // ================================================
    // Neighbor point index from the map, k never exceeds the slots
    assign nb_idx = map_arr[nb_cnt[SLOT_W-1:0]];

    // Each point owns chn_grp consecutive feature words
    assign ofm_rd_addr = job_cfg.ofm_rd_base
                       + idx_t'(job_cfg.chn_grp * nb_idx)
                       + idx_t'(grp_cnt);

endmodule

`default_nettype wire

/* max_reduce.sv */
// ================================================
// Lane-wise max over k feature beats per group and
// write-back of one result word per group
// ================================================
`timescale 1ns/1ns
`default_nettype none

module max_reduce import pool_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  pool_cfg_t job_cfg,
    input  logic      busy,
    input  lane_vec_t ofm_rd_dat,
    input  logic      ofm_rd_dat_valid,
    output logic      ofm_rd_dat_ready,
    output idx_t      ofm_wr_addr,
    output lane_vec_t ofm_wr_dat,
    output logic      ofm_wr_valid,
    input  logic      ofm_wr_ready,
    output logic      job_done
);

    kpt_t      beat_cnt;
    logic      beat_wrap;
    idx_t      res_cnt;
    logic      res_wrap;
    lane_vec_t acc;
    logic      rd_hs;
    logic      wr_hs;

    // Hold off data while a result is stuck at the output
    assign ofm_rd_dat_ready = busy && (!ofm_wr_valid || ofm_wr_ready);
    assign rd_hs            = ofm_rd_dat_valid && ofm_rd_dat_ready;
    assign wr_hs            = ofm_wr_valid && ofm_wr_ready;
    assign job_done         = wr_hs && res_wrap;

    pool_loop_counter #(.WIDTH($bits(kpt_t))) beat_cnt_i (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (!busy),
        .inc   (rd_hs),
        .max   (job_cfg.k - 1'b1),
        .count (beat_cnt),
        .wrap  (beat_wrap)
    );

    pool_loop_counter #(.WIDTH(IDX_WIDTH)) res_cnt_i (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (!busy),
        .inc   (wr_hs),
        .max   (idx_t'(job_cfg.nip * job_cfg.chn_grp - 1)),
        .count (res_cnt),
        .wrap  (res_wrap)
    );

    // First beat loads, later beats keep the unsigned max
    always_ff @(posedge clk) begin
        if (rd_hs) begin
            for (int i = 0; i < LANES; i++) begin
                if (beat_cnt == '0 || ofm_rd_dat[i] > acc[i]) begin
                    acc[i] <= ofm_rd_dat[i];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ofm_wr_valid <= 1'b0;
        end else if (!busy) begin
            ofm_wr_valid <= 1'b0;
        end else if (rd_hs && beat_wrap) begin
            ofm_wr_valid <= 1'b1;
        end else if (wr_hs) begin
            ofm_wr_valid <= 1'b0;
        end
    end

    assign ofm_wr_dat  = acc;
    assign ofm_wr_addr = job_cfg.ofm_wr_base + res_cnt;

endmodule

`default_nettype wire

/* pool_core.sv */
// ================================================
// Max-pooling core top level. Connects the job FSM,
// map fetch, feature gather and max reduction
// ================================================
`timescale 1ns/1ns
`default_nettype none

module pool_core import pool_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  pool_cfg_t  cfg,
    input  logic       cfg_valid,
    output logic       cfg_ready,
    output idx_t       map_rd_addr,
    output logic       map_rd_addr_valid,
    input  logic       map_rd_addr_ready,
    input  sram_word_t map_rd_dat,
    input  logic       map_rd_dat_valid,
    output logic       map_rd_dat_ready,
    output idx_t       ofm_rd_addr,
    output logic       ofm_rd_addr_valid,
    input  logic       ofm_rd_addr_ready,
    input  lane_vec_t  ofm_rd_dat,
    input  logic       ofm_rd_dat_valid,
    output logic       ofm_rd_dat_ready,
    output idx_t       ofm_wr_addr,
    output lane_vec_t  ofm_wr_dat,
    output logic       ofm_wr_valid,
    input  logic       ofm_wr_ready
);

    pool_cfg_t job_cfg;
    logic      busy;
    logic      fetch_done;
    logic      job_done;
    map_arr_t  map_arr;
    logic      map_valid;
    logic      map_ready;

    pool_ctrl_fsm ctrl_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg        (cfg),
        .cfg_valid  (cfg_valid),
        .cfg_ready  (cfg_ready),
        .fetch_done (fetch_done),
        .job_done   (job_done),
        .job_cfg    (job_cfg),
        .busy       (busy)
    );

    map_fetch map_fetch_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .job_cfg           (job_cfg),
        .busy              (busy),
        .map_rd_addr       (map_rd_addr),
        .map_rd_addr_valid (map_rd_addr_valid),
        .map_rd_addr_ready (map_rd_addr_ready),
        .map_rd_dat        (map_rd_dat),
        .map_rd_dat_valid  (map_rd_dat_valid),
        .map_rd_dat_ready  (map_rd_dat_ready),
        .map_arr           (map_arr),
        .map_valid         (map_valid),
        .map_ready         (map_ready),
        .fetch_done        (fetch_done)
    );

    ofm_gather gather_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .job_cfg           (job_cfg),
        .busy              (busy),
        .map_arr           (map_arr),
        .map_valid         (map_valid),
        .map_ready         (map_ready),
        .ofm_rd_addr       (ofm_rd_addr),
        .ofm_rd_addr_valid (ofm_rd_addr_valid),
        .ofm_rd_addr_ready (ofm_rd_addr_ready)
    );

    max_reduce reduce_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .job_cfg          (job_cfg),
        .busy             (busy),
        .ofm_rd_dat       (ofm_rd_dat),
        .ofm_rd_dat_valid (ofm_rd_dat_valid),
        .ofm_rd_dat_ready (ofm_rd_dat_ready),
        .ofm_wr_addr      (ofm_wr_addr),
        .ofm_wr_dat       (ofm_wr_dat),
        .ofm_wr_valid     (ofm_wr_valid),
        .ofm_wr_ready     (ofm_wr_ready),
        .job_done         (job_done)
    );

endmodule

`default_nettype wire

/* pool_tb.sv */
// ================================================
// Self-checking testbench for the pooling core
// Memory models and expected traffic come from the
// stim file and stall at random on every handshake
// ================================================
`timescale 1ns/1ns
`default_nettype none

module pool_tb import pool_pkg::*; ();

    // ================================================
    // Stim file layout
    // ================================================
    localparam int CFG_OFS     = 'h00;
    localparam int MAP_OFS     = 'h04;
    localparam int FEAT_OFS    = 'h0c;
    localparam int EXP_MAP_OFS = 'h14;
    localparam int EXP_RD_OFS  = 'h1c;
    localparam int EXP_WR_OFS  = 'h2c;
    localparam int STIM_DEPTH  = 'h32;
    localparam int NUM_JOBS    = 2;
    localparam int CFG_TIMEOUT = 50;
    localparam int JOB_TIMEOUT = 2000;

    logic       clk;
    logic       rst_n;
    pool_cfg_t  cfg;
    logic       cfg_valid;
    logic       cfg_ready;
    idx_t       map_rd_addr;
    logic       map_rd_addr_valid;
    logic       map_rd_addr_ready;
    sram_word_t map_rd_dat;
    logic       map_rd_dat_valid;
    logic       map_rd_dat_ready;
    idx_t       ofm_rd_addr;
    logic       ofm_rd_addr_valid;
    logic       ofm_rd_addr_ready;
    lane_vec_t  ofm_rd_dat;
    logic       ofm_rd_dat_valid;
    logic       ofm_rd_dat_ready;
    idx_t       ofm_wr_addr;
    lane_vec_t  ofm_wr_dat;
    logic       ofm_wr_valid;
    logic       ofm_wr_ready;

    logic [79:0] stim [0:STIM_DEPTH-1];
    idx_t        map_q[$];
    idx_t        rd_q[$];
    int          map_n;
    int          rd_n;
    int          wr_n;
    int          err_cnt;
    int          tests_ok;
    int          tests_bad;
    int          seed;
    logic        job_open;
    logic        ready_seen;
    logic        hung;

    pool_core dut_i (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // ================================================
    // Compare tasks
    // ================================================
    task automatic check_idx(input string what, input idx_t got, input idx_t exp);
        if (got !== exp) begin
            $display("FAILED %0t: %s got %h expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_lanes(input string what, input lane_vec_t got, input lane_vec_t exp);
        if (got !== exp) begin
            $display("FAILED %0t: %s got %h expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %0t: %s got %b expected %b", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    // Ready or valid is offered three times out of four
    function automatic logic draw_ready();
        return ($random(seed) & 3) != 0;
    endfunction

    task automatic close_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            tests_ok++;
            $display("test %s done, no errors", name);
        end else begin
            tests_bad++;
            $display("test %s done, %0d errors", name, err_cnt - errs_before);
        end
    endtask

    // ================================================
    // One clock of all memory models
    // ================================================
    task automatic cycle_models();
        logic        map_dhs;
        logic        rd_dhs;
        logic        cfg_hs;
        logic [79:0] exp_wr;
        // Mid-cycle, everything is settled until the next edge
        @(negedge clk);
        map_dhs    = map_rd_dat_valid && map_rd_dat_ready;
        rd_dhs     = ofm_rd_dat_valid && ofm_rd_dat_ready;
        cfg_hs     = cfg_valid && cfg_ready;
        ready_seen = cfg_ready;
        if (job_open) begin
            check_flag("cfg_ready before the final write", cfg_ready, 1'b0);
        end
        if (map_rd_addr_valid && map_rd_addr_ready) begin
            check_idx("map read address", map_rd_addr, idx_t'(stim[EXP_MAP_OFS + map_n]));
            map_q.push_back(map_rd_addr);
            map_n++;
        end
        if (ofm_rd_addr_valid && ofm_rd_addr_ready) begin
            check_idx("feature read address", ofm_rd_addr, idx_t'(stim[EXP_RD_OFS + rd_n]));
            rd_q.push_back(ofm_rd_addr);
            rd_n++;
        end
        if (ofm_wr_valid && ofm_wr_ready) begin
            exp_wr = stim[EXP_WR_OFS + wr_n];
            check_idx("write address", ofm_wr_addr, exp_wr[47:32]);
            check_lanes("write data", ofm_wr_dat, exp_wr[31:0]);
            wr_n++;
        end
        @(posedge clk);
        #2;
        if (cfg_hs) begin
            cfg_valid = 1'b0;
            job_open  = 1'b1;
        end
        // Read data returns in request order
        if (map_dhs) begin
            map_rd_dat_valid = 1'b0;
        end
        if (!map_rd_dat_valid && map_q.size() != 0 && draw_ready()) begin
            map_rd_dat       = stim[MAP_OFS + int'(map_q.pop_front())][SRAM_WIDTH-1:0];
            map_rd_dat_valid = 1'b1;
        end
        if (rd_dhs) begin
            ofm_rd_dat_valid = 1'b0;
        end
        if (!ofm_rd_dat_valid && rd_q.size() != 0 && draw_ready()) begin
            ofm_rd_dat       = stim[FEAT_OFS + int'(rd_q.pop_front())][31:0];
            ofm_rd_dat_valid = 1'b1;
        end
        map_rd_addr_ready = draw_ready();
        ofm_rd_addr_ready = draw_ready();
        ofm_wr_ready      = draw_ready();
    endtask

    // ================================================
    // Tests
    // ================================================
    task automatic check_reset();
        int errs_before;
        errs_before = err_cnt;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_flag("cfg_ready in reset", cfg_ready, 1'b1);
        check_flag("map_rd_addr_valid in reset", map_rd_addr_valid, 1'b0);
        check_flag("ofm_rd_addr_valid in reset", ofm_rd_addr_valid, 1'b0);
        check_flag("ofm_wr_valid in reset", ofm_wr_valid, 1'b0);
        @(posedge clk);
        #2;
        rst_n = 1'b1;
        cycle_models();
        check_flag("cfg_ready after reset", ready_seen, 1'b1);
        close_test("reset", errs_before);
    endtask

    task automatic run_job(input int j);
        pool_cfg_t c;
        int        errs_before;
        int        map_end;
        int        rd_end;
        int        wr_end;
        int        t;
        errs_before = err_cnt;
        c           = pool_cfg_t'(stim[CFG_OFS + j][$bits(pool_cfg_t)-1:0]);
        map_end     = map_n + int'(c.nip) * MAP_WORDS;
        rd_end      = rd_n + int'(c.nip) * int'(c.chn_grp) * int'(c.k);
        wr_end      = wr_n + int'(c.nip) * int'(c.chn_grp);
        cfg         = c;
        cfg_valid   = 1'b1;
        t = 0;
        while (!job_open && t < CFG_TIMEOUT) begin
            cycle_models();
            t++;
        end
        if (!job_open) begin
            $display("timeout, job %0d configuration was never taken", j);
            hung = 1'b1;
            err_cnt++;
        end
        t = 0;
        while (!hung && wr_n < wr_end && t < JOB_TIMEOUT) begin
            cycle_models();
            t++;
        end
        if (!hung && wr_n < wr_end) begin
            $display("timeout, job %0d wrote %0d of %0d results", j, wr_n, wr_end);
            hung = 1'b1;
            err_cnt++;
        end
        if (!hung) begin
            job_open = 1'b0;
            cycle_models();
            check_flag("cfg_ready after the final write", ready_seen, 1'b1);
            if (map_n != map_end || rd_n != rd_end) begin
                $display("FAILED %0t: job %0d made %0d map and %0d feature reads,",
                         $time, j, map_n, rd_n);
                $display("  expected %0d and %0d", map_end, rd_end);
                err_cnt++;
            end
        end
        close_test($sformatf("job %0d", j), errs_before);
    endtask

    initial begin
        seed              = 32'ha798_d071;
        rst_n             = 1'b0;
        cfg               = '0;
        cfg_valid         = 1'b0;
        map_rd_addr_ready = 1'b0;
        map_rd_dat        = '0;
        map_rd_dat_valid  = 1'b0;
        ofm_rd_addr_ready = 1'b0;
        ofm_rd_dat        = '0;
        ofm_rd_dat_valid  = 1'b0;
        ofm_wr_ready      = 1'b0;
        map_n             = 0;
        rd_n              = 0;
        wr_n              = 0;
        err_cnt           = 0;
        tests_ok          = 0;
        tests_bad         = 0;
        job_open          = 1'b0;
        ready_seen        = 1'b0;
        hung              = 1'b0;
        $readmemh("pool_stim.mem", stim);
        check_reset();
        for (int j = 0; j < NUM_JOBS && !hung; j++) begin
            run_job(j);
        end
        $display("tests passed %0d, failed %0d", tests_ok, tests_bad);
        if (hung || err_cnt != 0) begin
            $display("TEST FAILED");
        end else begin
            $display("TEST PASSED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* pool_stim.mem */
// Sections at fixed @ addresses. cfg is k(4) chn_grp(8) nip map_rd_base ofm_rd_base ofm_wr_base
// Map words hold entry 0 low. Features hold lane 0 low. Writes are address(16) then data(32)
@00
// job 0 with k 2, 2 groups, 2 points, writes from 0x40
2020002000000000040
// job 1 with k 3, 1 group, 2 points, map and features from 4, writes from 0x80
3010002000400040080
@04
// map image, two words per point
0003000100000002
0000000100020003
0000000200030001
0001000000030002
0000000200010003
0003000200010000
0001000300020000
0002000000010003
@0c
// feature image
108005FF
22019003
7F400610
05A01120
3002C008
117E0099
0181070A
EE003344
@14
// expected map read addresses, job 0 then job 1
0000 0001 0002 0003
0004 0005 0006 0007
@1c
// expected feature read addresses, job 0
0004 0000 0005 0001
0002 0006 0003 0007
// job 1
0007 0005 0006
0004 0006 0007
@2c
// expected writes, job 0
00403080C0FF
0041227E9099
00427F810710
0043EEA03344
// job 1
0080EE813399
0081EE81C044

/* list.f */
pool_pkg.sv
pool_loop_counter.sv
pool_ctrl_fsm.sv
map_fetch.sv
ofm_gather.sv
max_reduce.sv
pool_core.sv
pool_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= pool_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
